/* common/countdown_if.sv */
interface countdown_if;

    // one-cycle strobe, restarts the count
    logic load;
    // matrix enable
    logic show;
    game_pkg::pattern_e pattern;
    // high from count zero until the next load
    logic over;

    modport ctrl
    (
        output load,
        output show,
        output pattern,
        input  over
    );

    modport timer
    (
        input  load,
        input  show,
        input  pattern,
        output over
    );

endinterface

/* common/game_pkg.sv */
package game_pkg;

    // controller states, the round number lives in its own register
    typedef enum logic [1:0]
    {
        st_greet,
        st_play,
        st_judge,
        st_victory
    } game_state_e;

    // picture select for the dot matrix
    typedef enum logic [1:0]
    {
        pat_smile,
        pat_digit,
        pat_cross,
        pat_check
    } pattern_e;

    typedef enum logic
    {
        tone_low,
        tone_high
    } tone_e;

    localparam int ROUNDS       = 3;
    localparam int TARGET_W     = 7;
    localparam int ROUND_BASE_W = 5;

    localparam logic [TARGET_W-1:0] LFSR_SEED = 7'h5a;

    // short periods keep simulation fast
    localparam int COUNT_START = 5;
    localparam int TICK_CYCLES = 8;
    localparam int BEEP_CYCLES = 32;
    localparam int HALF_LOW    = 4;
    localparam int HALF_HIGH   = 2;

    // derived counter widths
    localparam int ROUND_W = $clog2(ROUNDS + 1);
    localparam int COUNT_W = $clog2(COUNT_START + 1);
    localparam int TICK_W  = $clog2(TICK_CYCLES);
    localparam int BEEP_W  = $clog2(BEEP_CYCLES + 1);
    localparam int HALF_W  = $clog2(HALF_LOW + 1);

endpackage

/* countdown/countdown_matrix.sv */
module countdown_matrix
(
    input  logic       clk,
    input  logic       sw,
    countdown_if.timer cd,
    output logic [7:0] row,
    output logic [7:0] colg,
    output logic [7:0] colr
);

    logic [game_pkg::TICK_W-1:0]  tick;
    logic [game_pkg::COUNT_W-1:0] count;
    logic [2:0]  scan;
    logic [63:0] glyph;
    logic [7:0]  line;
    logic        green;
    logic        red;

    // 8x8 font with the top row in the high byte
    function automatic logic [63:0] font(input logic [3:0] code);
        case (code)
            4'd0:    return 64'h3c666e7666663c00;
            4'd1:    return 64'h1838181818187e00;
            4'd2:    return 64'h3c66060c30607e00;
            4'd3:    return 64'h3c66061c06663c00;
            4'd4:    return 64'h0c1c3c6c7e0c0c00;
            4'd5:    return 64'h7e607c0606663c00;
            4'd6:    return 64'h3c42a581a599423c;
            4'd7:    return 64'h8142241818244281;
            4'd8:    return 64'h000103068cd87020;
            default: return 64'h0;
        endcase
    endfunction

    // tick divider and digit down-counter
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            tick    <= '0;
            count   <= '0;
            cd.over <= 1'b0;
        end
        else if (cd.load)
        begin
            // load cycle counts as the first tick
            tick    <= 1;
            count   <= game_pkg::COUNT_START[game_pkg::COUNT_W-1:0];
            cd.over <= 1'b0;
        end
        else if (count != 0)
        begin
            if (int'(tick) == game_pkg::TICK_CYCLES - 1)
            begin
                tick  <= '0;
                count <= count - 1'b1;
                if (count == 1)
                begin
                    cd.over <= 1'b1;
                end
            end
            else
            begin
                tick <= tick + 1'b1;
            end
        end
    end

    always_comb
    begin
        green = 1'b0;
        red   = 1'b0;
        case (cd.pattern)
            game_pkg::pat_smile:
            begin
                glyph = font(4'd6);
                green = 1'b1;
                red   = 1'b1;
            end
            game_pkg::pat_cross:
            begin
                glyph = font(4'd7);
                red   = 1'b1;
            end
            game_pkg::pat_check:
            begin
                glyph = font(4'd8);
                green = 1'b1;
            end
            default:
            begin
                // green while counting and red once time is up
                glyph = font({1'b0, count});
                green = !cd.over;
                red   = cd.over;
            end
        endcase
        line = glyph[8 * (7 - int'(scan)) +: 8];
    end

    // row scan with one active-low row per clock
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            scan <= '0;
            row  <= 8'hff;
            colg <= '0;
            colr <= '0;
        end
        else
        begin
            scan <= scan + 1'b1;
            if (cd.show)
            begin
                row  <= ~(8'h01 << scan);
                colg <= green ? line : 8'h00;
                colr <= red ? line : 8'h00;
            end
            else
            begin
                row  <= 8'hff;
                colg <= '0;
                colr <= '0;
            end
        end
    end

    a_one_row: assert property
    (
        @(posedge clk) disable iff (sw)
        cd.show |=> $onehot(~row)
    );

endmodule

/* files.f */
common/game_pkg.sv
common/countdown_if.sv
source/lfsr_random.sv
countdown/countdown_matrix.sv
source/beeper.sv
source/seg_display.sv
source/game_top.sv
sim/game_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds and runs the game testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module game_tb -f files.f -o game_sim &&
./obj_dir/game_sim | tee /dev/stderr | grep -q "Everything OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* sim/game_tb.sv */
module game_tb;

    localparam int PERIOD      = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int VICTORY     = game_pkg::ROUNDS + 1;
    // about 12 rounds of 60 cycles, with wide slack
    localparam int MAX_CYCLES  = 3000;

    // matrix pictures with the top row in the high byte
    localparam logic [63:0] SMILE_PIC = 64'h3c42a581a599423c;
    localparam logic [63:0] CROSS_PIC = 64'h8142241818244281;
    localparam logic [63:0] CHECK_PIC = 64'h000103068cd87020;
    localparam logic [63:0] ZERO_PIC  = 64'h3c666e7666663c00;

    logic        clk;
    logic        sw;
    logic        go;
    logic        submit;
    logic [6:0]  guess;
    logic [15:0] led;
    logic [7:0]  seg;
    logic [7:0]  dig;
    logic [7:0]  row;
    logic [7:0]  colg;
    logic [7:0]  colr;
    logic        beep;

    int         cycles = 0;
    int         cur_round;
    logic [6:0] target;
    logic [6:0] full_target;

    game_top UUT
    (
        .clk    (clk),
        .sw     (sw),
        .go     (go),
        .submit (submit),
        .guess  (guess),
        .led    (led),
        .seg    (seg),
        .dig    (dig),
        .row    (row),
        .colg   (colg),
        .colr   (colr),
        .beep   (beep)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES)
        begin
            stop_with_failure($sformatf("Timeout: the game did not finish within %0d cycles",
                                        MAX_CYCLES));
        end
    end

    // round r shows ROUND_BASE_W + r - 1 bits
    function automatic logic [6:0] round_mask(input int r);
        return 7'((1 << (game_pkg::ROUND_BASE_W + r - 1)) - 1);
    endfunction

    // active-low segments in the order dp g f e d c b a
    function automatic logic [7:0] seg_code(input int r);
        case (r)
            1:       return 8'hf9;
            2:       return 8'ha4;
            3:       return 8'hb0;
            default: return 8'hff;
        endcase
    endfunction

    // bit 3 is the high tone and bits 2:0 the next round
    function automatic logic [3:0] expected_step(input int r, input logic [6:0] shown,
                                                 input logic [6:0] value);
        logic [2:0] next_r;
        logic       high;
        if (((shown ^ value) & round_mask(r)) == 7'd0)
        begin
            high   = 1'b1;
            next_r = (r == game_pkg::ROUNDS) ? 3'(VICTORY) : 3'(r + 1);
        end
        else
        begin
            high   = 1'b0;
            next_r = 3'(r);
        end
        return {high, next_r};
    endfunction

    // picture byte for the row that is scanned now
    function automatic logic [7:0] pic_line(input logic [63:0] pic);
        int k;
        k = 0;
        for (int i = 0; i < 8; i++)
        begin
            if (!row[i])
                k = i;
        end
        return pic[8 * (7 - k) +: 8];
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            stop_with_failure($sformatf("Error: time %0t, %s expected 'h%0h, actual 'h%0h",
                                        $time, name, expected, actual));
        end
    endtask

    task automatic check_matrix(input logic [63:0] pic, input logic green, input logic red);
        logic [7:0] line;
        line = pic_line(pic);
        check_value("row zero count", 1, $countones(~row));
        check_value("colg", green ? line : 8'h00, colg);
        check_value("colr", red ? line : 8'h00, colr);
    endtask

    task automatic check_round(input int r);
        int tries;
        tries = 0;
        while (dig != 8'hfe && tries < 9)
        begin
            next_cycle();
            tries++;
        end
        if (dig != 8'hfe)
            stop_with_failure("The display never scanned the round digit");
        else
            check_value("seg", seg_code(r), seg);
    endtask

    // the player waits for the red zero
    task automatic wait_for_over();
        logic seen;
        seen = 1'b0;
        while (!seen)
        begin
            next_cycle();
            seen = (row != 8'hff) && (colg == 8'h00) && (colr != 8'h00)
                && (colr == pic_line(ZERO_PIC));
        end
    endtask

    task automatic judge_guess(input logic [6:0] value);
        logic [3:0] outcome;
        logic       want;
        int         next_round;
        int         half;
        outcome    = expected_step(cur_round, target, value);
        next_round = int'(outcome[2:0]);
        half       = outcome[3] ? game_pkg::HALF_HIGH : game_pkg::HALF_LOW;
        guess      = value;
        submit     = 1'b1;
        next_cycle();
        submit = 1'b0;
        // tone starts on the edge after judge
        for (int k = 1; k <= game_pkg::BEEP_CYCLES + 4; k++)
        begin
            next_cycle();
            want = (k <= game_pkg::BEEP_CYCLES) && ((((k - 1) / half) % 2) == 0);
            check_value("beep", want, beep);
            if (k >= 3 && k <= game_pkg::BEEP_CYCLES)
            begin
                if (next_round == VICTORY)
                    check_matrix(CHECK_PIC, 1'b1, 1'b0);
                else if (next_round == cur_round)
                    check_matrix(CROSS_PIC, 1'b0, 1'b1);
            end
        end
        if (next_round == VICTORY)
        begin
            check_value("led", 16'hffff, led);
            full_target = target;
            cur_round   = VICTORY;
        end
        else
        begin
            check_value("led", 0, led & ~16'(round_mask(next_round)));
            check_value("led", target, led[6:0] & round_mask(cur_round));
            cur_round = next_round;
            target    = led[6:0];
            check_round(cur_round);
        end
    endtask

    task automatic press_go();
        go = 1'b1;
        next_cycle();
        go = 1'b0;
    endtask

    initial
    begin
        logic [6:0] wrong;
        sw          = 1'b1;
        go          = 1'b0;
        submit      = 1'b0;
        guess       = 7'd0;
        cur_round   = 1;
        target      = 7'd0;
        full_target = 7'd0;
        void'($urandom(32'ha9d8156b));
        repeat (3) @(posedge clk);
        #(DRIVE_DELAY);
        sw = 1'b0;

        // greeting after reset
        check_value("led", 0, led);
        check_value("beep", 0, beep);
        check_value("dig", 8'hff, dig);
        repeat (8)
        begin
            next_cycle();
            check_matrix(SMILE_PIC, 1'b1, 1'b1);
            check_value("dig", 8'hff, dig);
        end

        // early submit in round 1 is ignored
        press_go();
        target = led[6:0];
        check_value("led", 0, led & ~16'(round_mask(1)));
        guess  = ~target;
        submit = 1'b1;
        repeat (game_pkg::COUNT_START * game_pkg::TICK_CYCLES - 2)
        begin
            next_cycle();
            check_value("led", {9'd0, target}, led);
            check_value("beep", 0, beep);
        end
        submit = 1'b0;
        check_round(1);

        // wrong guess repeats the round
        wait_for_over();
        wrong = 7'($urandom);
        if (((wrong ^ target) & round_mask(cur_round)) == 7'd0)
            wrong = wrong ^ 7'h01;
        judge_guess(wrong);
        check_round(1);

        // correct guesses through to victory
        while (cur_round != VICTORY)
        begin
            wait_for_over();
            judge_guess(target);
        end

        // go from victory and again in round 2
        press_go();
        cur_round = 1;
        target    = full_target & round_mask(1);
        check_value("led", {9'd0, target}, led);
        check_round(1);
        wait_for_over();
        judge_guess(target);
        check_round(2);
        press_go();
        cur_round = 1;
        target    = full_target & round_mask(1);
        check_value("led", {9'd0, target}, led);
        // fresh countdown shows green digits again
        repeat (3) next_cycle();
        check_value("colr", 8'h00, colr);
        check_round(1);
        wait_for_over();

        $display("Everything OK");
        $finish;
    end

endmodule

/* source/beeper.sv */
module beeper
(
    input  logic            clk,
    input  logic            sw,
    input  logic            trig,
    input  game_pkg::tone_e tone,
    output logic            beep
);

    logic [game_pkg::BEEP_W-1:0] len;
    logic [game_pkg::HALF_W-1:0] half_cnt;
    game_pkg::tone_e             tone_q;

    function automatic logic [game_pkg::HALF_W-1:0] half_of(input game_pkg::tone_e t);
        if (t == game_pkg::tone_high)
            return game_pkg::HALF_HIGH[game_pkg::HALF_W-1:0];
        else
            return game_pkg::HALF_LOW[game_pkg::HALF_W-1:0];
    endfunction

    // pitch held for the whole tone
    always_ff @(posedge clk)
    begin
        if (trig)
        begin
            tone_q <= tone;
        end
    end

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            len      <= '0;
            half_cnt <= '0;
            beep     <= 1'b0;
        end
        else if (trig)
        begin
            // a new trigger restarts the tone
            len      <= game_pkg::BEEP_CYCLES[game_pkg::BEEP_W-1:0];
            half_cnt <= half_of(tone);
            beep     <= 1'b1;
        end
        else if (len != 0)
        begin
            len <= len - 1'b1;
            if (len == 1)
            begin
                beep <= 1'b0;
            end
            else if (half_cnt == 1)
            begin
                beep     <= ~beep;
                half_cnt <= half_of(tone_q);
            end
            else
            begin
                half_cnt <= half_cnt - 1'b1;
            end
        end
    end

endmodule

/* source/game_top.sv */
module game_top
(
    input  logic        clk,
    input  logic        sw,
    input  logic        go,
    input  logic        submit,
    input  logic [6:0]  guess,
    output logic [15:0] led,
    output logic [7:0]  seg,
    output logic [7:0]  dig,
    output logic [7:0]  row,
    output logic [7:0]  colg,
    output logic [7:0]  colr,
    output logic        beep
);

    game_pkg::game_state_e state;
    game_pkg::game_state_e state_next;
    game_pkg::tone_e       tone;

    logic [game_pkg::ROUND_W-1:0]  round;
    logic [game_pkg::ROUND_W-1:0]  round_next;
    logic [game_pkg::TARGET_W-1:0] target;
    logic [game_pkg::TARGET_W-1:0] mask;
    logic hit;
    logic start_round;
    logic load_q;
    logic wrong;

    countdown_if cd_bus ();

    // generator only runs in greeting, so the target stays frozen afterwards
    lfsr_random u_lfsr
    (
        .clk   (clk),
        .sw    (sw),
        .run   (state == game_pkg::st_greet),
        .value (target)
    );

    countdown_matrix u_matrix
    (
        .clk  (clk),
        .sw   (sw),
        .cd   (cd_bus.timer),
        .row  (row),
        .colg (colg),
        .colr (colr)
    );

    seg_display u_seg
    (
        .clk   (clk),
        .sw    (sw),
        .show  (state != game_pkg::st_greet),
        .round (round),
        .seg   (seg),
        .dig   (dig)
    );

    beeper u_beep
    (
        .clk  (clk),
        .sw   (sw),
        .trig (state == game_pkg::st_judge),
        .tone (tone),
        .beep (beep)
    );

    // round r compares ROUND_BASE_W + r - 1 bits
    assign mask = ~({game_pkg::TARGET_W{1'b1}} << (game_pkg::ROUND_BASE_W + int'(round) - 1));
    assign hit  = ((guess ^ target) & mask) == '0;

    always_comb
    begin
        if (hit)
            tone = game_pkg::tone_high;
        else
            tone = game_pkg::tone_low;
    end

    always_comb
    begin
        state_next  = state;
        round_next  = round;
        start_round = 1'b0;
        if (go && state != game_pkg::st_judge)
        begin
            state_next  = game_pkg::st_play;
            round_next  = 1;
            start_round = 1'b1;
        end
        else
        begin
            case (state)
                game_pkg::st_play:
                begin
                    // over is stale during the load cycle
                    if (submit && cd_bus.over && !cd_bus.load)
                        state_next = game_pkg::st_judge;
                end
                game_pkg::st_judge:
                begin
                    if (!hit)
                    begin
                        state_next  = game_pkg::st_play;
                        start_round = 1'b1;
                    end
                    else if (int'(round) == game_pkg::ROUNDS)
                    begin
                        state_next = game_pkg::st_victory;
                    end
                    else
                    begin
                        state_next  = game_pkg::st_play;
                        round_next  = round + 1'b1;
                        start_round = 1'b1;
                    end
                end
                default:
                begin
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            state  <= game_pkg::st_greet;
            round  <= 1;
            load_q <= 1'b0;
            wrong  <= 1'b0;
        end
        else
        begin
            state  <= state_next;
            round  <= round_next;
            load_q <= start_round;
            // cross stays up until the next countdown ends
            if (state == game_pkg::st_judge)
                wrong <= !hit;
            else if (start_round || (cd_bus.over && !cd_bus.load))
                wrong <= 1'b0;
        end
    end

    always_comb
    begin
        cd_bus.load = load_q;
        // matrix blanks for the judge cycle
        cd_bus.show = (state != game_pkg::st_judge);
        case (state)
            game_pkg::st_greet:   cd_bus.pattern = game_pkg::pat_smile;
            game_pkg::st_victory: cd_bus.pattern = game_pkg::pat_check;
            default:              cd_bus.pattern = wrong ? game_pkg::pat_cross : game_pkg::pat_digit;
        endcase
    end

    always_comb
    begin
        led = '0;
        case (state)
            game_pkg::st_play, game_pkg::st_judge: led[game_pkg::TARGET_W-1:0] = target & mask;
            game_pkg::st_victory:                  led = '1;
            default:
            begin
            end
        endcase
    end

    a_judge_once: assert property
    (
        @(posedge clk) disable iff (sw)
        (state == game_pkg::st_judge) |=> (state != game_pkg::st_judge)
    );

endmodule

/* source/lfsr_random.sv */
module lfsr_random
(
    input  logic                         clk,
    input  logic                         sw,
    input  logic                         run,
    output logic [game_pkg::TARGET_W-1:0] value
);

    logic feedback;

    // taps for x^7 + x^6 + 1
    assign feedback = value[6] ^ value[5];

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            value <= game_pkg::LFSR_SEED;
        end
        else if (run)
        begin
            value <= {value[5:0], feedback};
        end
    end

    // all-zero would lock the generator up
    a_never_zero: assert property
    (
        @(posedge clk) disable iff (sw)
        value != '0
    );

endmodule

/* source/seg_display.sv */
module seg_display
(
    input  logic                        clk,
    input  logic                        sw,
    input  logic                        show,
    input  logic [game_pkg::ROUND_W-1:0] round,
    output logic [7:0]                  seg,
    output logic [7:0]                  dig
);

    logic [2:0] scan;
    logic [7:0] code;

    // segment order is dp g f e d c b a, all active low
    always_comb
    begin
        code = 8'hff;
        if (scan == 3'd0)
        begin
            case (round)
                2'd1:    code = 8'hf9;
                2'd2:    code = 8'ha4;
                2'd3:    code = 8'hb0;
                default: code = 8'hc0;
            endcase
        end
        else if (scan == 3'd7)
        begin
            // letter r
            code = 8'haf;
        end
    end

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            scan <= '0;
            seg  <= 8'hff;
            dig  <= 8'hff;
        end
        else
        begin
            scan <= scan + 1'b1;
            if (show)
            begin
                dig <= ~(8'h01 << scan);
                seg <= code;
            end
            else
            begin
                dig <= 8'hff;
                seg <= 8'hff;
            end
        end
    end

    a_one_digit: assert property
    (
        @(posedge clk) disable iff (sw)
        $onehot0(~dig)
    );

endmodule
